//--- Bender.yml
package:
  name: csr_index_configure_engine

sources:
  # Shared package
  - common/csr_cfg_pkg.sv
  # Design
  - verilog/sync_fifo.sv
  - config_assembly/response_ingress.sv
  - config_assembly/sequence_tracker.sv
  - config_assembly/config_field_decoder.sv
  - verilog/csr_index_configure_engine.sv
  # Testbench
  - target: test
    files:
      - dv/tb_csr_index_configure_engine.sv

//--- build.f
common/csr_cfg_pkg.sv
verilog/sync_fifo.sv
config_assembly/response_ingress.sv
config_assembly/sequence_tracker.sv
config_assembly/config_field_decoder.sv
verilog/csr_index_configure_engine.sv
dv/tb_csr_index_configure_engine.sv

//--- common/csr_cfg_pkg.sv
package csr_cfg_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    // One response data word
    localparam int DATA_W = 32;

    // Array pointer spans two data words
    localparam int ADDR_W = 2 * DATA_W;

    // Configuration words per sequence and selector width
    localparam int SEQ_COUNT = 8;
    localparam int SEQ_W     = $clog2(SEQ_COUNT);

    // Shift amount carried with each response
    localparam int SHIFT_W = 5;

    // ------------------------------------------------------------
    // Buffer class of a memory response
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        BUF_NONE         = 2'd0,
        BUF_CU_SETUP     = 2'd1,
        BUF_ENGINE_SETUP = 2'd2,
        BUF_GRAPH_DATA   = 2'd3
    } buffer_class_e;

    // ------------------------------------------------------------
    // Payload types
    // ------------------------------------------------------------
    // Incoming response word
    typedef struct packed {
        buffer_class_e        buffer_class;
        logic [DATA_W-1:0]    offset;
        logic [SHIFT_W-1:0]   shift_amount;
        logic [DATA_W-1:0]    data;
    } resp_packet_t;

    // Accepted word, selector relative to the engine window
    typedef struct packed {
        logic [SEQ_W-1:0]  sel;
        logic [DATA_W-1:0] data;
    } cfg_word_t;

    // Finished index configuration record
    typedef struct packed {
        logic              increment;
        logic              decrement;
        logic              mode_sequence;
        logic              mode_buffer;
        logic [DATA_W-1:0] index_start;
        logic [DATA_W-1:0] index_end;
        logic [DATA_W-1:0] stride;
        logic [DATA_W-2:0] granularity;
        logic              shift_direction;
        logic [ADDR_W-1:0] array_pointer;
        logic [DATA_W-1:0] array_size;
    } index_config_t;

endpackage : csr_cfg_pkg

//--- config_assembly/config_field_decoder.sv
module config_field_decoder import csr_cfg_pkg::*; (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          word_valid,
    input  cfg_word_t     word,
    input  logic          record_complete,
    output logic          record_push,
    output index_config_t record
);

    // Fields under assembly, kept between records
    index_config_t work;

    // ------------------------------------------------------------
    // Field decode
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid) begin
            case (word.sel)
                SEQ_W'(0): begin
                    work.increment     <= word.data[0];
                    work.decrement     <= word.data[1];
                    work.mode_sequence <= word.data[2];
                    work.mode_buffer   <= word.data[3];
                end
                SEQ_W'(1): work.index_start <= word.data;
                SEQ_W'(2): work.index_end   <= word.data;
                SEQ_W'(3): work.stride      <= word.data;
                SEQ_W'(4): begin
                    work.granularity     <= word.data[DATA_W-2:0];
                    work.shift_direction <= word.data[DATA_W-1];
                end
                // Pointer arrives as two halves
                SEQ_W'(5): work.array_pointer[DATA_W-1:0]      <= word.data;
                SEQ_W'(6): work.array_pointer[ADDR_W-1:DATA_W] <= word.data;
                SEQ_W'(7): work.array_size  <= word.data;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Record issue
    // ------------------------------------------------------------
    // Snapshot so a word of the next record cannot disturb the push
    always_ff @(posedge ap_clk) begin
        if (record_complete) begin
            record <= work;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            record_push <= 1'b0;
        end else begin
            record_push <= record_complete;
        end
    end

endmodule : config_field_decoder

//--- config_assembly/response_ingress.sv
module response_ingress import csr_cfg_pkg::*; #(
    parameter int SEQ_MIN = 0
) (
    input  logic         ap_clk,
    input  logic         areset_csr_index_generator,
    input  logic         resp_valid,
    input  resp_packet_t resp_packet,
    output logic         push,
    output cfg_word_t    word
);

    // Window bounds on the sequence index
    localparam logic [DATA_W-1:0] WIN_LO = DATA_W'(SEQ_MIN);
    localparam logic [DATA_W-1:0] WIN_HI = DATA_W'(SEQ_MIN + SEQ_COUNT);

    logic              resp_valid_q;
    resp_packet_t      resp_packet_q;
    logic [DATA_W-1:0] seq_index;
    logic [DATA_W-1:0] seq_rel;
    logic              class_ok;
    logic              window_ok;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_packet_q <= resp_packet;
    end

    // Sequence index from offset and shift
    assign seq_index = resp_packet_q.offset >> resp_packet_q.shift_amount;
    assign seq_rel   = seq_index - WIN_LO;

    // Only setup buffers inside our window
    assign class_ok  = (resp_packet_q.buffer_class == BUF_CU_SETUP) |
                       (resp_packet_q.buffer_class == BUF_ENGINE_SETUP);
    assign window_ok = (seq_index >= WIN_LO) & (seq_index < WIN_HI);

    assign push      = resp_valid_q & class_ok & window_ok;
    assign word.sel  = seq_rel[SEQ_W-1:0];
    assign word.data = resp_packet_q.data;

endmodule : response_ingress

//--- config_assembly/sequence_tracker.sv
module sequence_tracker import csr_cfg_pkg::*; (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             word_valid,
    input  logic [SEQ_W-1:0] word_sel,
    output logic             record_complete
);

    logic [SEQ_COUNT-1:0] mask;
    logic [SEQ_COUNT-1:0] mask_next;

    // Record done once every word has been seen
    assign record_complete = &mask;

    // ------------------------------------------------------------
    // Received-word mask
    // ------------------------------------------------------------
    always_comb begin
        // Start over after completion
        mask_next = record_complete ? '0 : mask;
        // A word may already belong to the next record
        if (word_valid) begin
            mask_next[word_sel] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            mask <= '0;
        end else begin
            mask <= mask_next;
        end
    end

endmodule : sequence_tracker

//--- dv/tb_csr_index_configure_engine.sv
module tb_csr_index_configure_engine import csr_cfg_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_MIN     = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    logic          ap_clk = 1'b0;
    logic          areset_csr_index_generator;
    logic          resp_valid;
    resp_packet_t  resp_packet;
    logic          response_prog_full;
    logic          config_ready;
    logic          config_valid;
    index_config_t config_record;

    // Stimulus table, cases point at their first word
    resp_packet_t  word_q[$];
    int            case_first[$];
    int            case_expect[$];
    bit            case_ready[$];
    string         case_name[$];
    bit            table_ready = 1'b0;
    int            scramble[9] = '{5, 2, 7, 0, 3, 6, 1, 2, 4};

    // Expected records built from the field map
    index_config_t        expected_q[$];
    index_config_t        model_work = '0;
    logic [SEQ_COUNT-1:0] model_mask = '0;
    int                   error_count = 0;
    int                   records_seen = 0;

    csr_index_configure_engine #(
        .SEQ_MIN    (SEQ_MIN),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) UUT (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_packet               (resp_packet),
        .response_prog_full        (response_prog_full),
        .config_ready              (config_ready),
        .config_valid              (config_valid),
        .config_record             (config_record)
    );

    always #2 ap_clk = ~ap_clk;

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic check_record(input string what, input index_config_t got,
                                input index_config_t exp);
        if (got !== exp) begin
            $display("FAILED at %t: %s got %h expected %h", $realtime, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %t: %s is %b, expected %b", $realtime, what, got, exp);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------
    // Table construction
    // ----------------------------------------------------------
    task automatic new_case(input string name, input bit ready, input int expect_n);
        case_name.push_back(name);
        case_ready.push_back(ready);
        case_expect.push_back(expect_n);
        case_first.push_back(word_q.size());
    endtask

    // Low offset bits below the shift must be dropped by the DUT
    task automatic add_word(input buffer_class_e cls, input int index, input int shift);
        resp_packet_t p;
        p.buffer_class = cls;
        p.offset       = (DATA_W'(index) << shift) | ((DATA_W'(1) << shift) - 1);
        p.shift_amount = SHIFT_W'(shift);
        p.data         = '0;
        word_q.push_back(p);
    endtask

    task automatic build_table();
        new_case("idle after reset", 1'b1, 0);
        new_case("in-order sequence", 1'b1, 1);
        for (int i = 0; i < SEQ_COUNT; i++) begin
            add_word(BUF_CU_SETUP, SEQ_MIN + i, 0);
        end
        new_case("scrambled order with a repeated word", 1'b1, 1);
        for (int i = 0; i < 9; i++) begin
            add_word(BUF_ENGINE_SETUP, SEQ_MIN + scramble[i], 0);
        end
        new_case("ignored words and one missing word", 1'b1, 0);
        for (int i = 0; i < SEQ_COUNT; i++) begin
            if (i != 6) begin
                add_word(BUF_CU_SETUP, SEQ_MIN + i, i % 4);
            end
        end
        // Each ignored word would fill the missing slot or clobber a field
        add_word(BUF_NONE, SEQ_MIN + 1, 0);
        add_word(BUF_GRAPH_DATA, SEQ_MIN + 6, 0);
        add_word(BUF_CU_SETUP, SEQ_MIN - 1, 0);
        add_word(BUF_ENGINE_SETUP, SEQ_MIN + SEQ_COUNT + 6, 0);
        new_case("missing word completes the record", 1'b1, 1);
        add_word(BUF_ENGINE_SETUP, SEQ_MIN + 6, 3);
        new_case("three records held with config_ready low", 1'b0, 3);
        for (int i = 0; i < 3 * SEQ_COUNT; i++) begin
            add_word(BUF_ENGINE_SETUP, SEQ_MIN + (i % SEQ_COUNT), 0);
        end
        table_ready = 1'b1;
    endtask

    // ----------------------------------------------------------
    // Reference model and driver
    // ----------------------------------------------------------
    task automatic model_word(input resp_packet_t p);
        logic [DATA_W-1:0] idx;
        bit                accept;
        int                sel;
        idx    = p.offset >> p.shift_amount;
        accept = (p.buffer_class == BUF_CU_SETUP || p.buffer_class == BUF_ENGINE_SETUP) &&
                 idx >= DATA_W'(SEQ_MIN) && idx < DATA_W'(SEQ_MIN + SEQ_COUNT);
        if (accept) begin
            sel = int'(idx) - SEQ_MIN;
            case (sel)
                0: {model_work.mode_buffer, model_work.mode_sequence,
                    model_work.decrement, model_work.increment} = p.data[3:0];
                1: model_work.index_start = p.data;
                2: model_work.index_end = p.data;
                3: model_work.stride = p.data;
                4: {model_work.shift_direction, model_work.granularity} = p.data;
                5: model_work.array_pointer[DATA_W-1:0] = p.data;
                6: model_work.array_pointer[ADDR_W-1:DATA_W] = p.data;
                default: model_work.array_size = p.data;
            endcase
            model_mask[sel] = 1'b1;
            if (&model_mask) begin
                expected_q.push_back(model_work);
                model_mask = '0;
            end
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_word(input resp_packet_t tmpl);
        resp_packet_t p;
        int           gap;
        p      = tmpl;
        p.data = $urandom;
        gap    = $urandom % 4;
        resp_valid  = 1'b1;
        resp_packet = p;
        model_word(p);
        @(negedge ap_clk);
        resp_valid = 1'b0;
        repeat (gap) @(negedge ap_clk);
    endtask

    // Monitor, config_valid is a one-cycle pulse
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && config_valid === 1'b1) begin
            records_seen++;
            if (config_ready !== 1'b1) begin
                $display("Record at %t came out while config_ready was held low", $realtime);
                error_count++;
            end
            if (expected_q.size() == 0) begin
                $display("Record at %t came out with no expected record waiting", $realtime);
                error_count++;
            end else begin
                check_record("config_record", config_record, expected_q.pop_front());
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (word_q.size() * 20 + 2000) @(posedge ap_clk);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int seed_sink;
        int last;
        int rec_before;
        int err_before;
        int waited;
        int pass_count;
        int fail_count;
        $timeformat(-9, 1, " ns", 10);
        seed_sink  = $urandom(32'h60a3c7b6);
        pass_count = 0;
        fail_count = 0;
        areset_csr_index_generator = 1'b1;
        resp_valid   = 1'b0;
        resp_packet  = '0;
        config_ready = 1'b0;
        build_table();
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;
        check_flag("config_valid after reset", config_valid, 1'b0);
        check_flag("response_prog_full after reset", response_prog_full, 1'b0);
        for (int c = 0; c < case_first.size(); c++) begin
            err_before   = error_count;
            rec_before   = records_seen;
            config_ready = case_ready[c];
            last = (c + 1 < case_first.size()) ? case_first[c + 1] : word_q.size();
            for (int w = case_first[c]; w < last; w++) begin
                send_word(word_q[w]);
            end
            // Quiet stretch, records stay queued while config_ready is low
            if (!case_ready[c] || last == case_first[c]) begin
                repeat (40) begin
                    @(negedge ap_clk);
                    check_flag("config_valid while held", config_valid, 1'b0);
                    check_flag("response_prog_full while held", response_prog_full, 1'b0);
                end
                config_ready = 1'b1;
            end
            waited = 0;
            while (expected_q.size() != 0 && waited < 200) begin
                @(negedge ap_clk);
                waited++;
            end
            // Room for a stray record to show up
            repeat (30) @(negedge ap_clk);
            if (expected_q.size() != 0) begin
                $display("Test %0d: %0d expected record(s) never came out", c, expected_q.size());
                error_count++;
                expected_q.delete();
            end
            if (records_seen - rec_before != case_expect[c]) begin
                $display("Test %0d: %0d record(s) expected but %0d came out", c,
                         case_expect[c], records_seen - rec_before);
                error_count++;
            end
            if (error_count == err_before) begin
                pass_count++;
                $display("Test %0d (%s): passed", c, case_name[c]);
            end else begin
                fail_count++;
                $display("Test %0d (%s): failed with %0d error(s)", c, case_name[c],
                         error_count - err_before);
            end
        end
        $display("Summary: %0d test(s) passed, %0d test(s) failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_csr_index_configure_engine

//--- verilog/csr_index_configure_engine.sv
module csr_index_configure_engine import csr_cfg_pkg::*; #(
    parameter int SEQ_MIN     = 0,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          resp_valid,
    input  resp_packet_t  resp_packet,
    output logic          response_prog_full,
    input  logic          config_ready,
    output logic          config_valid,
    output index_config_t config_record
);

    // Response path
    logic          resp_push;
    cfg_word_t     resp_word;
    logic          resp_rd_en;
    cfg_word_t     resp_dout;
    logic          resp_dout_valid;
    logic          resp_empty;

    // Record path
    logic          record_complete;
    logic          record_push;
    index_config_t record;
    logic          cfg_rd_en;
    index_config_t cfg_dout;
    logic          cfg_dout_valid;
    logic          cfg_empty;
    logic          cfg_prog_full;
    logic          config_ready_q;

    // ------------------------------------------------------------
    // Ingress and response queue
    // ------------------------------------------------------------
    response_ingress #(
        .SEQ_MIN(SEQ_MIN)
    ) u_ingress (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_packet               (resp_packet),
        .push                      (resp_push),
        .word                      (resp_word)
    );

    // Hold off while a record completes or the record queue backs up
    assign resp_rd_en = ~resp_empty & ~record_complete & ~cfg_prog_full;

    sync_fifo #(
        .payload_t  (cfg_word_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (resp_push),
        .din                       (resp_word),
        .rd_en                     (resp_rd_en),
        .dout                      (resp_dout),
        .dout_valid                (resp_dout_valid),
        .empty                     (resp_empty),
        .full                      (),
        .prog_full                 (response_prog_full)
    );

    // ------------------------------------------------------------
    // Record assembly
    // ------------------------------------------------------------
    sequence_tracker u_tracker (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (resp_dout_valid),
        .word_sel                  (resp_dout.sel),
        .record_complete           (record_complete)
    );

    config_field_decoder u_decoder (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (resp_dout_valid),
        .word                      (resp_dout),
        .record_complete           (record_complete),
        .record_push               (record_push),
        .record                    (record)
    );

    // ------------------------------------------------------------
    // Configuration queue and output register
    // ------------------------------------------------------------
    assign cfg_rd_en = config_ready_q & ~cfg_empty;

    sync_fifo #(
        .payload_t  (index_config_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (record_push),
        .din                       (record),
        .rd_en                     (cfg_rd_en),
        .dout                      (cfg_dout),
        .dout_valid                (cfg_dout_valid),
        .empty                     (cfg_empty),
        .full                      (),
        .prog_full                 (cfg_prog_full)
    );

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            config_ready_q <= 1'b0;
            config_valid   <= 1'b0;
        end else begin
            config_ready_q <= config_ready;
            config_valid   <= cfg_dout_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_record <= cfg_dout;
    end

endmodule : csr_index_configure_engine

//--- verilog/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t   = logic [31:0],
    parameter int  FIFO_DEPTH  = 16,
    parameter int  PROG_THRESH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_csr_index_generator,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     dout_valid,
    output logic     empty,
    output logic     full,
    output logic     prog_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);
    localparam logic [CNT_W-1:0] CNT_PROG = CNT_W'(PROG_THRESH);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Writes into a full buffer are dropped
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == CNT_FULL);
    assign prog_full = (count >= CNT_PROG);

    // ------------------------------------------------------------
    // Pointers, occupancy and read valid
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dout_valid <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            dout_valid <= do_rd;
        end
    end

    // Storage and registered read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo
